// ==== logic/ctx_cfg_pkg.sv ====
package ctx_cfg_pkg;

	// request and host addresses carry a 2-bit region field in their top bits
	localparam int region_bits = 2;
	localparam int region_lsb = 14;
	localparam int addr_bits = region_lsb + region_bits;

	// the two unused codes are ignored by the PU side
	typedef enum logic [region_bits-1:0] {
		region_unused0 = 2'd0,
		region_ctx = 2'd1,
		region_table = 2'd2,
		region_unused3 = 2'd3
	} mem_region_e;

	// below the region field a PU address holds {rci, offset}
	// a host address holds the table index or the context word address
	function automatic mem_region_e addr_region(input logic [addr_bits-1:0] addr);
		return mem_region_e'(addr[region_lsb +: region_bits]);
	endfunction

endpackage

// ==== logic/ctx_ops_pkg.sv ====
package ctx_ops_pkg;

	// taken straight from the Wishbone we line
	typedef enum logic {
		host_read = 1'b0,
		host_write = 1'b1
	} host_op_e;

	// the host sequencer only touches the memories in a cycle free of PU reads
	typedef enum logic [1:0] {
		host_idle = 2'd0,
		host_wait_slot = 2'd1,
		host_access = 2'd2,
		host_done = 2'd3
	} host_state_e;

	function automatic host_op_e op_from_we(input logic we);
		return host_op_e'(we);
	endfunction

endpackage

// ==== logic/pu_req_arbiter.sv ====
`timescale 1ns/1ps

module pu_req_arbiter import ctx_cfg_pkg::*; #(
	parameter int num_pu = 4,
	parameter int rci_bits = 8,
	parameter int off_bits = 4,
	localparam int id_bits = (num_pu > 1) ? $clog2(num_pu) : 1,
	localparam int lookup_bits = rci_bits + off_bits
) (
	input logic clk,
	input logic reset,
	input logic [num_pu-1:0] pu_req,
	input logic [num_pu*addr_bits-1:0] pu_addr,
	output logic grant_valid,
	output logic [id_bits-1:0] grant_id,
	output logic [lookup_bits-1:0] grant_addr
);

	logic [num_pu-1:0] accept;
	logic [num_pu-1:0] pending;
	logic [lookup_bits-1:0] addr_q [num_pu];
	logic [id_bits-1:0] last_id;
	logic pick_valid;
	logic [id_bits-1:0] pick_id;

	// requests outside the context region are dropped here without a reply
	always_comb begin
		for (int i = 0; i < num_pu; i++) begin
			accept[i] = pu_req[i] &&
				(addr_region(pu_addr[i*addr_bits +: addr_bits]) == region_ctx);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < num_pu; i++) begin
			if (accept[i])
				addr_q[i] <= pu_addr[i*addr_bits +: lookup_bits];
		end
	end

	// search from the PU after the last one granted; the nearest pending one wins
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_id = '0;
		for (int k = num_pu; k >= 1; k--) begin
			idx = (int'(last_id) + k) % num_pu;
			if (pending[idx]) begin
				pick_valid = 1'b1;
				pick_id = id_bits'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			grant_valid <= 1'b0;
			last_id <= id_bits'(num_pu - 1);
		end else begin
			for (int i = 0; i < num_pu; i++) begin
				if (pick_valid && pick_id == i)
					pending[i] <= 1'b0;
				if (accept[i])
					pending[i] <= 1'b1;
			end
			grant_valid <= pick_valid;
			if (pick_valid)
				last_id <= pick_id;
		end
	end

	always_ff @(posedge clk) begin
		if (pick_valid) begin
			grant_id <= pick_id;
			grant_addr <= addr_q[pick_id];
		end
	end

endmodule

// ==== logic/ctx_lookup_mem.sv ====
`timescale 1ns/1ps

module ctx_lookup_mem import ctx_cfg_pkg::*, ctx_ops_pkg::*; #(
	parameter int rci_bits = 8,
	parameter int sci_bits = 6,
	parameter int off_bits = 4,
	parameter int data_bits = 32,
	localparam int lookup_bits = rci_bits + off_bits,
	localparam int ctx_bits = sci_bits + off_bits
) (
	input logic clk,
	input logic reset,

	input logic grant_valid,
	input logic [lookup_bits-1:0] grant_addr,

	output logic ctx_valid,
	output logic [data_bits-1:0] ctx_data,

	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [addr_bits-1:0] wb_adr,
	input logic [data_bits-1:0] wb_dat_w,
	output logic wb_ack,
	output logic [data_bits-1:0] wb_dat_r
);

	logic [sci_bits-1:0] table_mem [2**rci_bits];
	logic [data_bits-1:0] ctx_mem [2**ctx_bits];

	host_state_e host_state;
	host_state_e host_state_next;
	host_op_e host_op_q;
	mem_region_e host_region_q;
	logic host_req;
	logic host_go;
	logic host_table_wr;
	logic host_ctx_wr;

	logic s1_valid;
	logic [off_bits-1:0] s1_off;
	logic [sci_bits-1:0] table_q;
	logic [rci_bits-1:0] table_addr;
	logic [ctx_bits-1:0] ctx_addr;

	assign host_req = wb_cyc && wb_stb;

	// a slot is free when neither pipeline stage holds a grant this cycle
	assign host_go = (host_state == host_access) && host_req && !grant_valid && !s1_valid;

	assign host_table_wr = host_go && (host_op_q == host_write) &&
		(host_region_q == region_table);
	assign host_ctx_wr = host_go && (host_op_q == host_write) &&
		(host_region_q == region_ctx);

	// each memory has a single port, shared by the PU pipeline and the host
	assign table_addr = host_go ? wb_adr[rci_bits-1:0] : grant_addr[lookup_bits-1:off_bits];
	assign ctx_addr = host_go ? wb_adr[ctx_bits-1:0] : {table_q, s1_off};

	// stage one turns the connection index into a slot index
	always_ff @(posedge clk) begin
		if (host_table_wr)
			table_mem[table_addr] <= wb_dat_w[sci_bits-1:0];
		table_q <= table_mem[table_addr];
		s1_off <= grant_addr[off_bits-1:0];
	end

	// stage two reads the word at {slot, offset}
	always_ff @(posedge clk) begin
		if (host_ctx_wr)
			ctx_mem[ctx_addr] <= wb_dat_w;
		ctx_data <= ctx_mem[ctx_addr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			ctx_valid <= 1'b0;
		end else begin
			s1_valid <= grant_valid;
			ctx_valid <= s1_valid;
		end
	end

	// op and region are latched once and held until the access completes
	always_ff @(posedge clk) begin
		if (host_state == host_idle && host_req) begin
			host_op_q <= op_from_we(wb_we);
			host_region_q <= addr_region(wb_adr);
		end
	end

	always_comb begin
		host_state_next = host_state;
		case (host_state)
			host_idle: begin
				if (host_req)
					host_state_next = host_wait_slot;
			end
			host_wait_slot: begin
				if (!host_req)
					host_state_next = host_idle;
				else if (!grant_valid && !s1_valid)
					host_state_next = host_access;
			end
			host_access: begin
				// a grant may still land in this cycle, so retry from the wait state
				if (host_go)
					host_state_next = host_done;
				else if (!host_req)
					host_state_next = host_idle;
				else
					host_state_next = host_wait_slot;
			end
			host_done: host_state_next = host_idle;
			default: host_state_next = host_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			host_state <= host_idle;
			wb_ack <= 1'b0;
		end else begin
			host_state <= host_state_next;
			wb_ack <= host_go;
		end
	end

	// in the ack cycle both read registers still hold the host's word
	always_comb begin
		case (host_region_q)
			region_table: wb_dat_r = data_bits'(table_q);
			region_ctx: wb_dat_r = ctx_data;
			default: wb_dat_r = '0;
		endcase
	end

endmodule

// ==== logic/ack_router.sv ====
`timescale 1ns/1ps

module ack_router #(
	parameter int num_pu = 4,
	parameter int data_bits = 32,
	localparam int id_bits = (num_pu > 1) ? $clog2(num_pu) : 1
) (
	input logic clk,
	input logic reset,
	input logic grant_valid,
	input logic [id_bits-1:0] grant_id,
	input logic ctx_valid,
	input logic [data_bits-1:0] ctx_data,
	output logic [num_pu-1:0] pu_ack,
	output logic [num_pu*data_bits-1:0] pu_rdata
);

	// one entry per grant in flight between the arbiter and the ack register
	localparam int fifo_depth = 3;

	logic [id_bits-1:0] tag_mem [fifo_depth];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [id_bits-1:0] head_id;

	function automatic logic [1:0] ptr_next(input logic [1:0] ptr);
		return (ptr == 2'(fifo_depth - 1)) ? 2'd0 : ptr + 2'd1;
	endfunction

	assign head_id = tag_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (grant_valid)
			tag_mem[wr_ptr] <= grant_id;
	end

	// results come back in grant order, so the oldest tag names the PU
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 2'd0;
			rd_ptr <= 2'd0;
		end else begin
			if (grant_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (ctx_valid)
				rd_ptr <= ptr_next(rd_ptr);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pu_ack <= '0;
			pu_rdata <= '0;
		end else begin
			for (int i = 0; i < num_pu; i++) begin
				pu_ack[i] <= ctx_valid && (head_id == i);
				pu_rdata[i*data_bits +: data_bits] <=
					(ctx_valid && (head_id == i)) ? ctx_data : '0;
			end
		end
	end

endmodule

// ==== logic/conn_context_top.sv ====
`timescale 1ns/1ps

module conn_context_top import ctx_cfg_pkg::*; #(
	parameter int num_pu = 4,
	parameter int rci_bits = 8,
	parameter int sci_bits = 6,
	parameter int off_bits = 4,
	parameter int data_bits = 32,
	localparam int id_bits = (num_pu > 1) ? $clog2(num_pu) : 1
) (
	input logic clk,
	input logic reset,

	input logic [num_pu-1:0] pu_req,
	input logic [num_pu*addr_bits-1:0] pu_addr,
	output logic [num_pu-1:0] pu_ack,
	output logic [num_pu*data_bits-1:0] pu_rdata,

	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [addr_bits-1:0] wb_adr,
	input logic [data_bits-1:0] wb_dat_w,
	output logic wb_ack,
	output logic [data_bits-1:0] wb_dat_r
);

	logic grant_valid;
	logic [id_bits-1:0] grant_id;
	logic [rci_bits+off_bits-1:0] grant_addr;
	logic ctx_valid;
	logic [data_bits-1:0] ctx_data;

	pu_req_arbiter #(
		.num_pu(num_pu),
		.rci_bits(rci_bits),
		.off_bits(off_bits)
	) arb0 (
		.clk(clk),
		.reset(reset),
		.pu_req(pu_req),
		.pu_addr(pu_addr),
		.grant_valid(grant_valid),
		.grant_id(grant_id),
		.grant_addr(grant_addr)
	);

	ctx_lookup_mem #(
		.rci_bits(rci_bits),
		.sci_bits(sci_bits),
		.off_bits(off_bits),
		.data_bits(data_bits)
	) mem0 (
		.clk(clk),
		.reset(reset),
		.grant_valid(grant_valid),
		.grant_addr(grant_addr),
		.ctx_valid(ctx_valid),
		.ctx_data(ctx_data),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r)
	);

	ack_router #(
		.num_pu(num_pu),
		.data_bits(data_bits)
	) route0 (
		.clk(clk),
		.reset(reset),
		.grant_valid(grant_valid),
		.grant_id(grant_id),
		.ctx_valid(ctx_valid),
		.ctx_data(ctx_data),
		.pu_ack(pu_ack),
		.pu_rdata(pu_rdata)
	);

endmodule

// ==== dv/conn_context_checker.sv ====
`timescale 1ns/1ps

module conn_context_checker #(
	parameter int num_pu = 4,
	parameter int data_bits = 32
) (
	input logic clk,
	input logic reset,
	input logic [num_pu-1:0] pu_ack,
	input logic [num_pu*data_bits-1:0] pu_rdata,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	int assert_errors = 0;

	assert property (@(posedge clk) disable iff (reset) $onehot0(pu_ack))
	else begin
		$error("pu_ack has more than one bit set");
		assert_errors++;
	end

	assert property (@(posedge clk) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb))
	else begin
		$error("wb_ack without an active cycle");
		assert_errors++;
	end

	// the ack is a single pulse per access
	assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
	else begin
		$error("wb_ack held for two cycles");
		assert_errors++;
	end

	// registered outputs are cleared after the first reset edge
	assert property (@(posedge clk) (reset && $past(reset)) |->
			(pu_ack == '0 && pu_rdata == '0 && !wb_ack))
	else begin
		$error("outputs active during reset");
		assert_errors++;
	end

endmodule

bind conn_context_top conn_context_checker #(
	.num_pu(num_pu),
	.data_bits(data_bits)
) chk0 (
	.clk(clk),
	.reset(reset),
	.pu_ack(pu_ack),
	.pu_rdata(pu_rdata),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack)
);

// ==== dv/conn_context_tb.sv ====
`timescale 1ns/1ps

module conn_context_tb import ctx_cfg_pkg::*, ctx_ops_pkg::*;;
	localparam int num_pu = 4;
	localparam int rci_bits = 8;
	localparam int sci_bits = 6;
	localparam int off_bits = 4;
	localparam int data_bits = 32;
	localparam int ctx_bits = sci_bits + off_bits;
	localparam int clk_period = 4;
	// cycles allowed for one trace line including gaps and host waits
	localparam int line_budget = 80;

	logic clk = 1'b0;
	logic reset;
	logic [num_pu-1:0] pu_req;
	logic [num_pu*addr_bits-1:0] pu_addr;
	logic [num_pu-1:0] pu_ack;
	logic [num_pu*data_bits-1:0] pu_rdata;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [addr_bits-1:0] wb_adr;
	logic [data_bits-1:0] wb_dat_w;
	logic wb_ack;
	logic [data_bits-1:0] wb_dat_r;

	// host writes keep these copies of both memories up to date
	logic [sci_bits-1:0] table_m [2**rci_bits];
	logic [data_bits-1:0] ctx_m [2**ctx_bits];

	logic [31:0] field [11];
	int last_grant = num_pu - 1;
	int line_count = 0;
	int data_errors = 0;
	int proto_errors = 0;

	conn_context_top #(
		.num_pu(num_pu),
		.rci_bits(rci_bits),
		.sci_bits(sci_bits),
		.off_bits(off_bits),
		.data_bits(data_bits)
	) dut0 (.*);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_pu_data(input int id, input logic [data_bits-1:0] got,
			input logic [data_bits-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: PU %0d read %h, expected %h", $time, id, got, exp);
			data_errors++;
		end
	endtask

	task automatic check_host_read(input host_op_e op, input logic [addr_bits-1:0] adr,
			input logic [data_bits-1:0] got, input logic [data_bits-1:0] exp);
		if (op == host_read && got !== exp) begin
			$display("** Error at %0t: host read of %h returned %h, expected %h",
				$time, adr, got, exp);
			data_errors++;
		end
	endtask

	function automatic logic [data_bits-1:0] model_read(input logic [addr_bits-1:0] adr);
		if (adr[region_lsb +: region_bits] == region_table)
			return data_bits'(table_m[adr[rci_bits-1:0]]);
		return ctx_m[adr[ctx_bits-1:0]];
	endfunction

	task automatic host_transfer(input host_op_e op, input logic [addr_bits-1:0] adr,
			input logic [data_bits-1:0] wdata, output logic [data_bits-1:0] rdata);
		int cycles;
		cycles = 0;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= (op == host_write);
		wb_adr <= adr;
		wb_dat_w <= wdata;
		do begin
			@(negedge clk);
			cycles++;
		end while (!wb_ack && cycles < 50);
		if (!wb_ack) begin
			$display("host access to address %h was never acknowledged", adr);
			proto_errors++;
		end
		rdata = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic pu_burst();
		logic [num_pu-1:0] mask;
		logic [addr_bits-1:0] a;
		logic [data_bits-1:0] exp_w [num_pu];
		logic [num_pu-1:0] accepted;
		int order[$];
		int idx;
		int cycles;
		mask = field[0][num_pu-1:0];
		for (int i = 0; i < num_pu; i++) begin
			a = field[1+i][addr_bits-1:0];
			accepted[i] = mask[i] && (a[region_lsb +: region_bits] == region_ctx);
			exp_w[i] = ctx_m[{table_m[a[off_bits +: rci_bits]], a[off_bits-1:0]}];
			if (accepted[i] && exp_w[i] !== field[5+i]) begin
				$display("trace expectation for PU %0d disagrees with the memory model", i);
				data_errors++;
			end
		end
		// grants follow the PU after the last one granted
		for (int k = 1; k <= num_pu; k++) begin
			idx = (last_grant + k) % num_pu;
			if (accepted[idx])
				order.push_back(idx);
		end
		if (order.size() > 0)
			last_grant = order[$];
		@(posedge clk);
		pu_req <= mask;
		for (int i = 0; i < num_pu; i++)
			pu_addr[i*addr_bits +: addr_bits] <= field[1+i][addr_bits-1:0];
		@(posedge clk);
		pu_req <= '0;
		cycles = 0;
		while (order.size() > 0 && cycles < 30) begin
			@(negedge clk);
			cycles++;
			for (int i = 0; i < num_pu; i++) begin
				if (pu_ack[i]) begin
					if (order.size() > 0 && order[0] == i) begin
						check_pu_data(i, pu_rdata[i*data_bits +: data_bits], exp_w[i]);
						void'(order.pop_front());
					end else begin
						$display("PU %0d got an acknowledge out of order or without a request", i);
						proto_errors++;
					end
				end else begin
					// fields without an acknowledge read as zero
					check_pu_data(i, pu_rdata[i*data_bits +: data_bits], '0);
				end
			end
		end
		if (order.size() > 0) begin
			$display("%0d acknowledges missing after the burst, next PU %0d",
				order.size(), order[0]);
			proto_errors++;
		end
		// no further acknowledge may arrive for this burst
		repeat (8) begin
			@(negedge clk);
			if (pu_ack != '0) begin
				$display("extra acknowledge seen, pu_ack = %b", pu_ack);
				proto_errors++;
			end
		end
	endtask

	// the watchdog budget follows the number of operations in the trace
	initial begin
		wait (line_count > 0);
		#(line_count * line_budget * clk_period);
		$display("watchdog expired before the trace was finished");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int fd;
		int n;
		string line;
		string op;
		logic [data_bits-1:0] rd;
		void'($urandom(91198));
		reset = 1'b1;
		pu_req = '0;
		pu_addr = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		fd = $fopen("dv/conn_context_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file dv/conn_context_trace.txt");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			n = 0;
			while ($fgets(line, fd)) begin
				if (line.len() > 1 && line.substr(0, 0) != "#")
					n++;
			end
			$fclose(fd);
			line_count = n + 1;
			repeat (3) @(posedge clk);
			reset <= 1'b0;
			fd = $fopen("dv/conn_context_trace.txt", "r");
			while ($fgets(line, fd)) begin
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", op,
					field[0], field[1], field[2], field[3], field[4], field[5],
					field[6], field[7], field[8], field[9], field[10]);
				if (op == "W") begin
					host_transfer(host_write, field[0][addr_bits-1:0], field[1], rd);
					if (field[0][region_lsb +: region_bits] == region_table)
						table_m[field[0][rci_bits-1:0]] = field[1][sci_bits-1:0];
					else
						ctx_m[field[0][ctx_bits-1:0]] = field[1];
				end else if (op == "R") begin
					if (model_read(field[0][addr_bits-1:0]) !== field[1]) begin
						$display("trace expectation for host read disagrees with the model");
						data_errors++;
					end
					host_transfer(host_read, field[0][addr_bits-1:0], '0, rd);
					check_host_read(host_read, field[0][addr_bits-1:0], rd, field[1]);
				end else if (op == "P") begin
					pu_burst();
				end else if (op == "H") begin
					// host read issued while the burst is running
					fork
						pu_burst();
						begin
							host_transfer(host_read, field[9][addr_bits-1:0], '0, rd);
							check_host_read(host_read, field[9][addr_bits-1:0], rd, field[10]);
						end
					join
				end else begin
					$display("unknown trace operation %s", op);
					proto_errors++;
				end
				repeat ($urandom_range(3)) @(posedge clk);
			end
			$fclose(fd);
			$display("errors: data %0d, protocol %0d, assertion %0d",
				data_errors, proto_errors, dut0.chk0.assert_errors);
			if (data_errors == 0 && proto_errors == 0 &&
					dut0.chk0.assert_errors == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

endmodule

// ==== dv/conn_context_trace.txt ====
# W adr data | R adr expected | P mask a0 a1 a2 a3 e0 e1 e2 e3
# H is P followed by a concurrent host read: host_adr expected (all values hex)
W 8005 3
W 8010 20
W 8022 7
W 803a 3f
W 4030 dead0030
W 4031 dead0031
W 4202 cafe2002
W 4075 beef0075
W 43ff 12345fff
W 43f1 0f0f03f1
R 8010 20
R 803a 3f
R 4202 cafe2002
R 43f1 0f0f03f1
P 1 4050 0 0 0 dead0030 0 0 0
P 4 0 0 4102 0 0 0 cafe2002 0
P 8 0 0 0 43af 0 0 0 12345fff
P f 4050 4102 4225 43af dead0030 cafe2002 beef0075 12345fff
P f 4051 43a1 4050 4225 dead0031 0f0f03f1 dead0030 beef0075
P 2 0 c050 0 0 0 0 0 0
P a 0 8050 0 4225 0 0 0 beef0075
W 8005 3f
R 8005 3f
P 1 4051 0 0 0 0f0f03f1 0 0 0
H f 4102 4225 43af 4051 cafe2002 beef0075 12345fff 0f0f03f1 4075 beef0075
W 4030 11112222
H 5 4225 0 43a1 0 beef0075 0 0f0f03f1 0 8022 7
P 3 4102 4225 0 0 cafe2002 beef0075 0 0

// ==== compile.f ====
logic/ctx_cfg_pkg.sv
logic/ctx_ops_pkg.sv
logic/pu_req_arbiter.sv
logic/ctx_lookup_mem.sv
logic/ack_router.sv
logic/conn_context_top.sv
dv/conn_context_checker.sv
dv/conn_context_tb.sv

// ==== Bender.yml ====
package:
  name: conn_context

sources:
  - files:
      - logic/ctx_cfg_pkg.sv
      - logic/ctx_ops_pkg.sv
      - logic/pu_req_arbiter.sv
      - logic/ctx_lookup_mem.sv
      - logic/ack_router.sv
      - logic/conn_context_top.sv
  - target: test
    files:
      - dv/conn_context_checker.sv
      - dv/conn_context_tb.sv
